//--- common/rvPkg.sv
/*
 * rvCore shared definitions
 * ISA widths, opcode and ALU encodings, pipeline register layouts
 */
`default_nettype none

package rvPkg;

	// architectural widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;

	// integer register file depth
	localparam int regCount = 32;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_t;

	// ALU operations, ADD first so a cleared field means add
	typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} aluOp_t;

	// where an execute operand comes from
	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSel_t;

	// decode -> execute
	typedef struct packed {
		word_t    pc;
		word_t    pcPlus4;
		word_t    opA;
		word_t    opB;
		word_t    imm;
		regAddr_t rs1;
		regAddr_t rs2;
		regAddr_t rd;
		aluOp_t   aluOp;
		logic     aluSrcImm;
		logic     link;
		logic     lui;
		logic     auipc;
		logic     memRead;
		logic     memWrite;
		logic [2:0] funct3;
		logic     regWrite;
		logic     valid;
	} decExReg_t;

	// execute -> memory
	typedef struct packed {
		word_t    aluResult;
		word_t    storeData;
		regAddr_t rd;
		logic [2:0] funct3;
		logic     memRead;
		logic     memWrite;
		logic     regWrite;
		logic     valid;
	} exMemReg_t;

	// memory -> writeback, load/alu choice already made
	typedef struct packed {
		word_t    result;
		regAddr_t rd;
		logic     regWrite;
	} memWbReg_t;

endpackage

`default_nettype wire

//--- dv/programInput.hex
// word 0 is the program length, then the program words from address 0,
// then the record count, then records of address, merged store word, byte mask
0000006B
// alu ops on 100 and -7, stores to 0x100
06400093 FF900113 002081B3 40208233 0020C2B3 0020E333 0020F3B3
10302023 10402223 10502423 10602623 10702823
// shifts, immediate and register forms
00309413 40215493 01C15513 00A095B3 40115633 001156B3
10802A23 10902C23 10A02E23 12B02023 12C02223 12D02423
// slt, sltu, sltiu, lui and auipc
00112733 001137B3 FFF0B813 12E02623 12F02823 13002A23
ABCDE8B7 00001917 13102C23 13202E23
// forwarding chain, stores to 0x180
00500093 00108133 001101B3 00208233 18302023 18402223 18202423
// word 0x80f7a5c3 at 0x200, then loads each used at once
80F7A2B7 5C328293 20502023
20100303 00030393 20702223
20304303 00030393 20702423
20201303 00030393 20702623
20005303 00030393 20702823
20002303 20602A23
// sb at every offset of 0x280, sh at both halves of 0x284
5A600413 28502023 28800023 288000A3 28800123 288001A3
28502223 28801223 28801323
// taken branches, each skipping a store to 0x3fc
00000593
00108463 3E102E23 00209463 3E102E23 0014C463 3E102E23
0090D463 3E102E23 0090E463 3E102E23 0014F463 3E102E23
// not-taken branches, each counting in x11
00208463 00158593 00109463 00158593 0090C463 00158593
0014D463 00158593 0014E463 00158593 0090F463 00158593
30B02023
// branch on alu result, branch on load, jal, jalr, then a self loop
00700693 00069463 3E102E23
30002703 00B70463 3E102E23
008007EF 3E102E23 30F02223
1A500813 000808E7 3E102E23 31102423
0000006F
00000024
00000100 0000005D 0000000F
00000104 0000006B 0000000F
00000108 FFFFFF9D 0000000F
0000010C FFFFFFFD 0000000F
00000110 00000060 0000000F
00000114 00000320 0000000F
00000118 FFFFFFFE 0000000F
0000011C 0000000F 0000000F
00000120 00320000 0000000F
00000124 FFFFFFFF 0000000F
00000128 0FFFFFFF 0000000F
0000012C 00000001 0000000F
00000130 00000000 0000000F
00000134 00000001 0000000F
00000138 ABCDE000 0000000F
0000013C 0000107C 0000000F
00000180 0000000F 0000000F
00000184 0000000F 0000000F
00000188 0000000A 0000000F
00000200 80F7A5C3 0000000F
00000204 FFFFFFA5 0000000F
00000208 00000080 0000000F
0000020C FFFF80F7 0000000F
00000210 0000A5C3 0000000F
00000214 80F7A5C3 0000000F
00000280 80F7A5C3 0000000F
00000280 80F7A5A6 00000001
00000280 80F7A6A6 00000002
00000280 80A6A6A6 00000004
00000280 A6A6A6A6 00000008
00000284 80F7A5C3 0000000F
00000284 80F705A6 00000003
00000284 05A605A6 0000000C
00000300 00000006 0000000F
00000304 00000190 0000000F
00000308 000001A0 0000000F

//--- dv/rvCoreChecker.sv
/*
 * rvCore bound checks on the data port, the pc and the hazard controls
 */
`default_nettype none

module rvCoreChecker import rvPkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  dataWriteEnable,
	input word_t pc,
	input logic  stall,
	input logic  flush
);
	timeunit 1ns;
	timeprecision 1ps;

	// write strobe must be a clean level once out of reset
	writeEnableKnown: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown(dataWriteEnable))
		else $error("dataWriteEnable is unknown");

	// fetch only ever steps or jumps to word addresses
	pcWordAligned: assert property (@(posedge clk) disable iff (!reset)
		pc[1:0] == 2'b00)
		else $error("pc 0x%08h is not word aligned", pc);

	// a stall freezes fetch even with a redirect pending
	stallHoldsPc: assert property (@(posedge clk) disable iff (!reset)
		stall |=> $stable(pc))
		else $error("pc moved while fetch was stalled");

endmodule

bind rvCore rvCoreChecker coreChecks (
	.clk(clk), .reset(reset), .dataWriteEnable(dataWriteEnable),
	.pc(pc), .stall(stall), .flush(flush)
);

`default_nettype wire

//--- dv/rvCoreTb.sv
/*
 * rvCore testbench with memory models, program load from the input file,
 * in-order store checking and a per-section report
 */
`default_nettype none

module rvCoreTb import rvPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk, reset, dataWriteEnable;
	word_t instrAddr, instr, dataAddr, dataWriteData, dataReadData;

	// flat image of the input file
	word_t fileWords [1024];
	word_t imem [256];
	word_t dmem [256];
	int progLen, recCount, recIdx, cycles, cycleLimit;
	int passCount, failCount;
	int secChecks [5];
	int secErrors [5];
	int secLast [5];
	string secNames [5];

	rvCore rvCore_inst (
		.clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .dataWriteData(dataWriteData),
		.dataWriteEnable(dataWriteEnable), .dataReadData(dataReadData)
	);

	always #4 clk = ~clk;

	// both memories answer in the same cycle
	assign instr = imem[instrAddr[9:2]];
	assign dataReadData = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (reset && dataWriteEnable) begin
			dmem[dataAddr[9:2]] <= dataWriteData;
		end
	end

	// each section stores into its own 128-byte window from 0x100 up
	function automatic int sectionOf(input word_t addr);
		int s;
		s = int'(addr[9:7]) - 2;
		if (s < 0 || s > 4) begin
			s = 0;
		end
		return s;
	endfunction

	// records are address, merged word, byte mask
	function automatic word_t recordWord(input int rec, input int field);
		return fileWords[progLen + 2 + 3 * rec + field];
	endfunction

	task automatic countCheck(input bit ok, input int sec);
		secChecks[sec]++;
		if (ok) begin
			passCount++;
		end else begin
			failCount++;
			secErrors[sec]++;
		end
	endtask

	task automatic checkStore();
		word_t expAddr, expData, expMask, oldWord;
		int sec, b;
		bit ok;
		if (recIdx >= recCount) begin
			assert (recIdx < recCount) else begin
				$display("unexpected store to address 0x%08h after all expected stores",
					dataAddr);
				failCount++;
			end
		end else begin
			expAddr = recordWord(recIdx, 0);
			expData = recordWord(recIdx, 1);
			expMask = recordWord(recIdx, 2);
			sec = sectionOf(expAddr);
			oldWord = dmem[expAddr[9:2]];
			ok = (dataAddr === expAddr);
			assert (ok) else $display("Mismatch dataAddr: got 0x%08h expected 0x%08h",
				dataAddr, expAddr);
			countCheck(ok, sec);
			ok = (dataWriteData === expData);
			assert (ok) else $display("Mismatch dataWriteData: got 0x%08h expected 0x%08h",
				dataWriteData, expData);
			countCheck(ok, sec);
			// bytes outside the mask must come back unchanged
			for (b = 0; b < 4; b++) begin
				if (!expMask[b]) begin
					ok = (dataWriteData[8*b +: 8] === oldWord[8*b +: 8]);
					assert (ok) else $display("store to 0x%08h changed byte %0d outside its mask",
						dataAddr, b);
					countCheck(ok, sec);
				end
			end
			if (recIdx == secLast[sec]) begin
				$display("section %0d %s: %0d checks, %0d errors", sec + 1, secNames[sec],
					secChecks[sec], secErrors[sec]);
			end
			recIdx++;
		end
	endtask

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin
		if (reset && dataWriteEnable === 1'b1) begin
			checkStore();
		end
	end

	initial begin
		int i;
		clk = 1'b0;
		reset = 1'b0;
		recIdx = 0;
		cycles = 0;
		passCount = 0;
		failCount = 0;
		secNames[0] = "alu and immediate ops";
		secNames[1] = "forwarding";
		secNames[2] = "loads and load-use";
		secNames[3] = "byte and half stores";
		secNames[4] = "control flow";
		$readmemh("dv/programInput.hex", fileWords);
		if ($isunknown(fileWords[0])) begin
			$display("could not read a program from dv/programInput.hex");
			failCount++;
			progLen = 0;
			recCount = 0;
		end else begin
			progLen = int'(fileWords[0]);
			recCount = int'(fileWords[progLen + 1]);
		end
		for (i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end
		for (i = 0; i < progLen && i < 256; i++) begin
			imem[i] = fileWords[i + 1];
		end
		for (i = 0; i < 5; i++) begin
			secChecks[i] = 0;
			secErrors[i] = 0;
			secLast[i] = -1;
		end
		for (i = 0; i < recCount; i++) begin
			secLast[sectionOf(recordWord(i, 0))] = i;
		end
		cycleLimit = 3 * progLen + 64;
		repeat (16) @(posedge clk);
		reset <= 1'b1;
		while (recIdx < recCount && cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		assert (recIdx >= recCount) else begin
			$display("timeout after %0d cycles with %0d of %0d stores not seen",
				cycles, recCount - recIdx, recCount);
			failCount++;
		end
		// a late wrong-path store would still show up here
		repeat (8) @(posedge clk);
		$display("checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
common/rvPkg.sv
logic/regFile.sv
logic/alu.sv
logic/pcGen.sv
pipeline/decodeStage.sv
pipeline/executeStage.sv
pipeline/hazardUnit.sv
pipeline/memoryStage.sv
pipeline/rvCore.sv
dv/rvCoreChecker.sv
dv/rvCoreTb.sv

//--- logic/alu.sv
/*
 * RV32I integer ALU for the ten register/immediate operations
 */
`default_nettype none

module alu import rvPkg::*; (
	input  word_t  srcA,
	input  word_t  srcB,
	input  aluOp_t op,
	output word_t  result
);

	logic [4:0] shamt;

	// shifts only look at the low five bits
	assign shamt = srcB[4:0];

	always_comb begin
		case (op)
			ADD:  result = srcA + srcB;
			SUB:  result = srcA - srcB;
			SLL:  result = srcA << shamt;
			// signed compare
			SLT:  result = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
			SLTU: result = (srcA < srcB) ? 32'd1 : 32'd0;
			XOR:  result = srcA ^ srcB;
			SRL:  result = srcA >> shamt;
			// arithmetic shift keeps the sign bit
			SRA:  result = $signed(srcA) >>> shamt;
			OR:   result = srcA | srcB;
			AND:  result = srcA & srcB;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/pcGen.sv
/*
 * program counter register and next-pc selection
 */
`default_nettype none

module pcGen import rvPkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  stall,
	input  logic  redirect,
	input  word_t redirectTarget,
	output word_t pc,
	output word_t pcPlus4
);

	// fetch always predicts not-taken
	assign pcPlus4 = pc + 32'd4;

	// reset vector is address 0, decode redirect beats stall
	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirectTarget;
		end else if (!stall) begin
			pc <= pcPlus4;
		end
	end

endmodule

`default_nettype wire

//--- logic/regFile.sv
/*
 * integer register file, two combinational reads and one write on the falling edge
 */
`default_nettype none

module regFile import rvPkg::*; (
	input  logic     clk,
	input  logic     writeEnable,
	input  regAddr_t readAddrA,
	input  regAddr_t readAddrB,
	input  regAddr_t writeAddr,
	input  word_t    writeData,
	output word_t    readDataA,
	output word_t    readDataB
);

	word_t regs [regCount];

	// negedge write so decode sees writeback data in the same cycle
	always_ff @(negedge clk) begin
		if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 is hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- pipeline/decodeStage.sv
/*
 * decode stage: control decode, immediates, register read,
 * memory-stage forwarding and early branch/jump resolution
 */
`default_nettype none

module decodeStage import rvPkg::*; (
	input  logic      clk,
	input  word_t     instr,
	input  word_t     pc,
	input  word_t     pcPlus4,
	input  memWbReg_t wbReg,
	input  word_t     memForward,
	input  logic      fwdA,
	input  logic      fwdB,
	output decExReg_t decEx,
	output logic      redirect,
	output word_t     redirectTarget,
	output regAddr_t  srcA,
	output regAddr_t  srcB
);

	opcode_t opcode;
	logic [2:0] funct3;
	word_t immI, immS, immB, immU, immJ;
	word_t rfA, rfB, opA, opB;
	logic usesA, usesB, taken;

	// alt selects SUB (register form only) and SRA
	function automatic aluOp_t aluDecode(input logic [2:0] f3, input logic alt, input logic isReg);
		case (f3)
			3'b000:  return (alt && isReg) ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b011:  return SLTU;
			3'b100:  return XOR;
			3'b101:  return alt ? SRA : SRL;
			3'b110:  return OR;
			default: return AND;
		endcase
	endfunction

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];

	// immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// unused source fields read as x0 so they never raise hazards
	assign usesA = opcode inside {OP, OP_IMM, LOAD, STORE, BRANCH, JALR};
	assign usesB = opcode inside {OP, STORE, BRANCH};
	assign srcA = usesA ? instr[19:15] : '0;
	assign srcB = usesB ? instr[24:20] : '0;

	regFile regs (
		.clk        (clk),
		.writeEnable(wbReg.regWrite),
		.readAddrA  (srcA),
		.readAddrB  (srcB),
		.writeAddr  (wbReg.rd),
		.writeData  (wbReg.result),
		.readDataA  (rfA),
		.readDataB  (rfB)
	);

	// writeback comes through the negedge write, memory through this bypass
	assign opA = fwdA ? memForward : rfA;
	assign opB = fwdB ? memForward : rfB;

	always_comb begin
		case (funct3)
			3'b000:  taken = (opA == opB);
			3'b001:  taken = (opA != opB);
			3'b100:  taken = ($signed(opA) < $signed(opB));
			3'b101:  taken = ($signed(opA) >= $signed(opB));
			3'b110:  taken = (opA < opB);
			3'b111:  taken = (opA >= opB);
			default: taken = 1'b0;
		endcase
	end

	// redirect target, JALR clears bit 0
	always_comb begin
		redirect = 1'b0;
		redirectTarget = pc + immB;
		case (opcode)
			BRANCH: redirect = taken;
			JAL: begin
				redirect = 1'b1;
				redirectTarget = pc + immJ;
			end
			JALR: begin
				redirect = 1'b1;
				redirectTarget = (opA + immI) & ~32'd1;
			end
			default: redirect = 1'b0;
		endcase
	end

	always_comb begin
		decEx = '0;
		decEx.pc = pc;
		decEx.pcPlus4 = pcPlus4;
		decEx.opA = opA;
		decEx.opB = opB;
		decEx.rs1 = srcA;
		decEx.rs2 = srcB;
		decEx.rd = instr[11:7];
		decEx.funct3 = funct3;
		decEx.valid = 1'b1;
		case (opcode)
			OP: begin
				decEx.aluOp = aluDecode(funct3, instr[30], 1'b1);
				decEx.regWrite = 1'b1;
			end
			OP_IMM: begin
				decEx.imm = immI;
				decEx.aluSrcImm = 1'b1;
				decEx.aluOp = aluDecode(funct3, instr[30], 1'b0);
				decEx.regWrite = 1'b1;
			end
			LOAD: begin
				decEx.imm = immI;
				decEx.aluSrcImm = 1'b1;
				decEx.memRead = 1'b1;
				decEx.regWrite = 1'b1;
			end
			STORE: begin
				decEx.imm = immS;
				decEx.aluSrcImm = 1'b1;
				decEx.memWrite = 1'b1;
			end
			// resolved here, nothing left to do downstream
			BRANCH: decEx.imm = immB;
			JAL, JALR: begin
				decEx.link = 1'b1;
				decEx.regWrite = 1'b1;
			end
			LUI: begin
				decEx.imm = immU;
				decEx.lui = 1'b1;
				decEx.regWrite = 1'b1;
			end
			AUIPC: begin
				decEx.imm = immU;
				decEx.auipc = 1'b1;
				decEx.regWrite = 1'b1;
			end
			// unknown or bubble word
			default: decEx.valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- pipeline/executeStage.sv
/*
 * execute stage: operand forwarding, ALU and result select
 */
`default_nettype none

module executeStage import rvPkg::*; (
	input  decExReg_t decEx,
	input  word_t     memResult,
	input  word_t     wbResult,
	input  fwdSel_t   fwdSelA,
	input  fwdSel_t   fwdSelB,
	output exMemReg_t exMem
);

	word_t srcA, srcB, aluB, aluOut, result;

	function automatic word_t pickOperand(input fwdSel_t sel, input word_t regValue,
			input word_t memValue, input word_t wbValue);
		case (sel)
			FWD_MEM: return memValue;
			FWD_WB:  return wbValue;
			default: return regValue;
		endcase
	endfunction

	// bypass from memory and writeback
	assign srcA = pickOperand(fwdSelA, decEx.opA, memResult, wbResult);
	assign srcB = pickOperand(fwdSelB, decEx.opB, memResult, wbResult);
	assign aluB = decEx.aluSrcImm ? decEx.imm : srcB;

	alu aluUnit (
		.srcA  (srcA),
		.srcB  (aluB),
		.op    (decEx.aluOp),
		.result(aluOut)
	);

	// link, lui and auipc bypass the ALU
	always_comb begin
		if (decEx.link) begin
			result = decEx.pcPlus4;
		end else if (decEx.lui) begin
			result = decEx.imm;
		end else if (decEx.auipc) begin
			result = decEx.pc + decEx.imm;
		end else begin
			result = aluOut;
		end
	end

	always_comb begin
		exMem.aluResult = result;
		// store data is the forwarded rs2 value
		exMem.storeData = srcB;
		exMem.rd = decEx.rd;
		exMem.funct3 = decEx.funct3;
		exMem.memRead = decEx.memRead;
		exMem.memWrite = decEx.memWrite;
		exMem.regWrite = decEx.regWrite;
		exMem.valid = decEx.valid;
	end

endmodule

`default_nettype wire

//--- pipeline/hazardUnit.sv
/*
 * hazard unit: forwarding selects, load-use and branch stalls, decode flush
 */
`default_nettype none

module hazardUnit import rvPkg::*; (
	input  regAddr_t  decSrcA,
	input  regAddr_t  decSrcB,
	input  logic      decUsesBranchSrc,
	input  decExReg_t decEx,
	input  exMemReg_t exMem,
	input  memWbReg_t memWb,
	input  logic      redirect,
	output logic      fwdDecA,
	output logic      fwdDecB,
	output fwdSel_t   fwdSelA,
	output fwdSel_t   fwdSelB,
	output logic      stall,
	output logic      flush
);

	logic exWrites, memWrites, memAluWrites;
	logic exDep, memLoadDep, loadUse, branchOnEx, branchOnLoad;

	// x0 never matches
	function automatic logic hits(input regAddr_t dst, input logic wr, input regAddr_t src);
		return wr && (dst != '0) && (dst == src);
	endfunction

	assign exWrites = decEx.valid && decEx.regWrite;
	assign memWrites = exMem.valid && exMem.regWrite;
	assign memAluWrites = memWrites && !exMem.memRead;

	// execute operands, memory wins over writeback
	assign fwdSelA = hits(exMem.rd, memWrites, decEx.rs1) ? FWD_MEM :
		hits(memWb.rd, memWb.regWrite, decEx.rs1) ? FWD_WB : FWD_REG;
	assign fwdSelB = hits(exMem.rd, memWrites, decEx.rs2) ? FWD_MEM :
		hits(memWb.rd, memWb.regWrite, decEx.rs2) ? FWD_WB : FWD_REG;

	// decode bypass only carries ALU results
	assign fwdDecA = hits(exMem.rd, memAluWrites, decSrcA);
	assign fwdDecB = hits(exMem.rd, memAluWrites, decSrcB);

	assign exDep = hits(decEx.rd, exWrites, decSrcA) || hits(decEx.rd, exWrites, decSrcB);
	assign memLoadDep = exMem.memRead &&
		(hits(exMem.rd, memWrites, decSrcA) || hits(exMem.rd, memWrites, decSrcB));

	assign loadUse = exDep && decEx.memRead;
	assign branchOnEx = exDep && decUsesBranchSrc;
	assign branchOnLoad = memLoadDep && decUsesBranchSrc;

	assign stall = loadUse || branchOnEx || branchOnLoad;
	// a stalled branch resolves again next cycle
	assign flush = redirect && !stall;

endmodule

`default_nettype wire

//--- pipeline/memoryStage.sv
/*
 * memory stage: load extraction, store merging and writeback select
 */
`default_nettype none

module memoryStage import rvPkg::*; (
	input  exMemReg_t exMem,
	input  word_t     dataReadData,
	output word_t     dataAddr,
	output word_t     dataWriteData,
	output logic      dataWriteEnable,
	output memWbReg_t memWb
);

	logic [1:0] offset;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;
	word_t loadValue;

	// word address, byte lanes picked by offset
	assign offset = exMem.aluResult[1:0];
	assign dataAddr = {exMem.aluResult[31:2], 2'b00};
	assign dataWriteEnable = exMem.valid && exMem.memWrite;

	// half accesses align down to the half boundary
	assign loadByte = dataReadData[{offset, 3'b000} +: 8];
	assign loadHalf = dataReadData[{offset[1], 4'b0000} +: 16];

	always_comb begin
		case (exMem.funct3)
			3'b000:  loadValue = {{24{loadByte[7]}}, loadByte};
			3'b001:  loadValue = {{16{loadHalf[15]}}, loadHalf};
			3'b100:  loadValue = {24'b0, loadByte};
			3'b101:  loadValue = {16'b0, loadHalf};
			default: loadValue = dataReadData;
		endcase
	end

	// untouched bytes come from the current memory word
	always_comb begin
		dataWriteData = dataReadData;
		case (exMem.funct3[1:0])
			2'b00:   dataWriteData[{offset, 3'b000} +: 8] = exMem.storeData[7:0];
			2'b01:   dataWriteData[{offset[1], 4'b0000} +: 16] = exMem.storeData[15:0];
			default: dataWriteData = exMem.storeData;
		endcase
	end

	always_comb begin
		memWb.result = exMem.memRead ? loadValue : exMem.aluResult;
		memWb.rd = exMem.rd;
		memWb.regWrite = exMem.valid && exMem.regWrite;
	end

endmodule

`default_nettype wire

//--- pipeline/rvCore.sv
/*
 * rvCore top level: five-stage RV32I pipeline registers and stage wiring
 */
`default_nettype none

module rvCore import rvPkg::*; (
	input  logic  clk,
	input  logic  reset,
	output word_t instrAddr,
	input  word_t instr,
	output word_t dataAddr,
	output word_t dataWriteData,
	output logic  dataWriteEnable,
	input  word_t dataReadData
);

	word_t pc, pcPlus4, redirectTarget;
	word_t fdInstr, fdPc, fdPcPlus4, decInstr;
	logic fdValid;
	decExReg_t decExNext, decExQ;
	exMemReg_t exMemNext, exMemQ;
	memWbReg_t memWbNext, memWbQ;
	logic redirect, stall, flush, fwdDecA, fwdDecB, decUsesBranchSrc;
	regAddr_t decSrcA, decSrcB;
	fwdSel_t fwdSelA, fwdSelB;
	opcode_t decOpcode;

	// a committed redirect is exactly the flush condition
	pcGen fetch (
		.clk(clk), .reset(reset), .stall(stall), .redirect(flush),
		.redirectTarget(redirectTarget), .pc(pc), .pcPlus4(pcPlus4)
	);
	assign instrAddr = pc;

	// fetch/decode register, flushed on redirect, held on stall
	always_ff @(posedge clk) begin
		if (!reset) begin
			fdValid <= 1'b0;
		end else if (flush) begin
			fdValid <= 1'b0;
		end else if (!stall) begin
			fdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fdInstr <= instr;
			fdPc <= pc;
			fdPcPlus4 <= pcPlus4;
		end
	end

	// an empty slot decodes as an all-zero word, which is no instruction
	assign decInstr = fdValid ? fdInstr : '0;
	assign decOpcode = opcode_t'(decInstr[6:0]);
	assign decUsesBranchSrc = decOpcode inside {BRANCH, JALR};

	decodeStage decode (
		.clk(clk), .instr(decInstr), .pc(fdPc), .pcPlus4(fdPcPlus4), .wbReg(memWbQ),
		.memForward(exMemQ.aluResult), .fwdA(fwdDecA), .fwdB(fwdDecB), .decEx(decExNext),
		.redirect(redirect), .redirectTarget(redirectTarget), .srcA(decSrcA), .srcB(decSrcB)
	);

	// decode/execute register, bubble on stall
	always_ff @(posedge clk) begin
		if (!reset || stall) begin
			decExQ.valid <= 1'b0;
		end else begin
			decExQ <= decExNext;
		end
	end

	executeStage execute (
		.decEx(decExQ), .memResult(exMemQ.aluResult), .wbResult(memWbQ.result),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .exMem(exMemNext)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			exMemQ.valid <= 1'b0;
		end else begin
			exMemQ <= exMemNext;
		end
	end

	memoryStage memory (
		.exMem(exMemQ), .dataReadData(dataReadData), .dataAddr(dataAddr),
		.dataWriteData(dataWriteData), .dataWriteEnable(dataWriteEnable), .memWb(memWbNext)
	);

	always_ff @(posedge clk) begin
		if (!reset) begin
			memWbQ.regWrite <= 1'b0;
		end else begin
			memWbQ <= memWbNext;
		end
	end

	hazardUnit hazards (
		.decSrcA(decSrcA), .decSrcB(decSrcB), .decUsesBranchSrc(decUsesBranchSrc),
		.decEx(decExQ), .exMem(exMemQ), .memWb(memWbQ), .redirect(redirect),
		.fwdDecA(fwdDecA), .fwdDecB(fwdDecB), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
		.stall(stall), .flush(flush)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rvCoreTb \
	-o rvCoreSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rvCoreSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
